// ==== bench/ccipFabricTb.sv ====
/*
 * directed testbench for the request fabric
 * clock, reset, LFSR data source, model memory, check task,
 * directed tests and watchdog
 */
`default_nettype none

module ccipFabricTb
   import ccipPkg::*;
();

   localparam int ClkPeriod   = 4;
   localparam int ResetCycles = 4;
   // handshake wait limit per edge of ack
   localparam int AckLimit    = 40;
   // reset, then the cycle budgets of the five tests
   localparam int WatchdogCycles = 20 + 60 + 120 + 60 + 140 + 160;

   logic                  clk = 1'b0;
   logic                  rstN;
   logic                  req0;
   reqHdr_u               hdr0;
   logic                  ack0;
   logic                  req1;
   reqHdr_u               hdr1;
   logic [DataWidth-1:0]  data1;
   logic                  ack1;
   logic                  rspValid;
   logic [DataWidth-1:0]  rspData;
   logic [TagWidth-1:0]   rspTag;
   logic [CountWidth-1:0] violCount;
   logic [2:0]            lastViol;

   // expected contents
   logic [DataWidth-1:0] model [2**AddrWidth];
   logic [DataWidth-1:0] modelCfg [CfgRegs];
   // collected response beats
   logic [DataWidth-1:0] beatData [$];
   logic [TagWidth-1:0]  beatTag [$];
   int                   beatCyc [$];

   logic [15:0] lfsrState = 16'd83;
   int cycleCount = 0;
   int errCount = 0;
   int passCount = 0;
   int failCount = 0;

   ccipFabric dut_i (
      .clk(clk), .rstN(rstN),
      .req0(req0), .hdr0(hdr0), .ack0(ack0),
      .req1(req1), .hdr1(hdr1), .data1(data1), .ack1(ack1),
      .rspValid(rspValid), .rspData(rspData), .rspTag(rspTag),
      .violCount(violCount), .lastViol(lastViol)
   );

   always #(ClkPeriod / 2) clk = ~clk;

   always @(posedge clk) cycleCount <= cycleCount + 1;

   // response stream, sampled mid-cycle
   always @(negedge clk) begin
      if (rspValid === 1'b1) begin
         beatData.push_back(rspData);
         beatTag.push_back(rspTag);
         beatCyc.push_back(cycleCount);
      end
   end

   // galois LFSR, taps 16,14,13,11
   function automatic logic [15:0] stepLfsr(input logic [15:0] s);
      logic [15:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 16'hB400;
      end
      return n;
   endfunction

   // one bit per step
   task automatic randWord(output logic [DataWidth-1:0] w);
      for (int i = 0; i < DataWidth; i++) begin
         w[i] = lfsrState[0];
         lfsrState = stepLfsr(lfsrState);
      end
   endtask

   function automatic reqHdr_u memHdr(input logic [1:0] t, input logic [1:0] len,
         input logic [AddrWidth-1:0] addr, input logic [TagWidth-1:0] tag);
      reqHdr_u h;
      h = '0;
      h.mem.reqType = t;
      h.mem.len = len;
      h.mem.addr = addr;
      h.mem.mdata = tag;
      return h;
   endfunction

   function automatic reqHdr_u cfgHdr(input logic [1:0] t, input logic [5:0] index,
         input logic [TagWidth-1:0] tid);
      reqHdr_u h;
      h = '0;
      h.cfg.reqType = t;
      h.cfg.index = index;
      h.cfg.tid = tid;
      return h;
   endfunction

   task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
         errCount++;
      end
   endtask

   task automatic endTest(input int num, input string name, input int startErr);
      if (errCount == startErr) begin
         passCount++;
         $display("test %0d %s: ok", num, name);
      end else begin
         failCount++;
         $display("test %0d %s: %0d errors", num, name, errCount - startErr);
      end
   endtask

   task automatic applyReset();
      @(posedge clk);
      #1;
      rstN = 1'b0;
      repeat (ResetCycles) @(posedge clk);
      #1;
      rstN = 1'b1;
   endtask

   // wait for ack of one channel to reach a level
   task automatic waitAck(input bit chan, input logic level);
      int n;
      n = 0;
      @(negedge clk);
      while ((chan ? ack1 : ack0) !== level && n < AckLimit) begin
         @(negedge clk);
         n++;
      end
      if ((chan ? ack1 : ack0) !== level) begin
         $display("channel %0d: ack did not reach %0b within %0d cycles", chan, level, n);
         errCount++;
      end
   endtask

   // full four-phase transfers
   task automatic chan0Op(input reqHdr_u h);
      @(posedge clk);
      #1;
      req0 = 1'b1;
      hdr0 = h;
      waitAck(1'b0, 1'b1);
      @(posedge clk);
      #1;
      req0 = 1'b0;
      waitAck(1'b0, 1'b0);
   endtask

   task automatic chan1Op(input reqHdr_u h, input logic [DataWidth-1:0] d);
      @(posedge clk);
      #1;
      req1 = 1'b1;
      hdr1 = h;
      data1 = d;
      waitAck(1'b1, 1'b1);
      @(posedge clk);
      #1;
      req1 = 1'b0;
      waitAck(1'b1, 1'b0);
   endtask

   task automatic clearBeats();
      beatData.delete();
      beatTag.delete();
      beatCyc.delete();
   endtask

   // n beats from model memory in wrap order, back to back
   task automatic checkBeats(input logic [AddrWidth-1:0] addr, input int n,
         input logic [TagWidth-1:0] tag);
      logic [AddrWidth-1:0] a;
      checkVal("beat count", 32'(beatData.size()), 32'(n));
      for (int i = 0; i < n && i < beatData.size(); i++) begin
         a = addr + AddrWidth'(i);
         checkVal("rspData", beatData[i], model[a]);
         checkVal("rspTag", 32'(beatTag[i]), 32'(tag));
         checkVal("beat cycle", 32'(beatCyc[i] - beatCyc[0]), 32'(i));
      end
   endtask

   task automatic checkViol(input int count, input logic [2:0] code);
      checkVal("violCount", 32'(violCount), 32'(count));
      checkVal("lastViol", 32'(lastViol), 32'(code));
   endtask

   task automatic testBasic();
      int startErr;
      logic [DataWidth-1:0] d;
      startErr = errCount;
      checkVal("ack0", 32'(ack0), 32'd0);
      checkVal("ack1", 32'(ack1), 32'd0);
      checkVal("rspValid", 32'(rspValid), 32'd0);
      checkViol(0, ViolNone);
      randWord(d);
      chan1Op(memHdr(ReqWrLine, Len1, 6'd3, 4'h1), d);
      model[3] = d;
      clearBeats();
      chan0Op(memHdr(ReqRdLine, Len1, 6'd3, 4'h7));
      checkBeats(6'd3, 1, 4'h7);
      checkViol(0, ViolNone);
      endTest(1, "write then read", startErr);
   endtask

   task automatic testWrap();
      int startErr;
      logic [DataWidth-1:0] d;
      logic [AddrWidth-1:0] a;
      startErr = errCount;
      // lines 62, 63, 0, 1
      for (int i = 0; i < 4; i++) begin
         a = 6'd62 + AddrWidth'(i);
         randWord(d);
         chan1Op(memHdr(ReqWrLine, Len1, a, 4'h2), d);
         model[a] = d;
      end
      clearBeats();
      chan0Op(memHdr(ReqRdLine, Len4, 6'd62, 4'hC));
      checkBeats(6'd62, 4, 4'hC);
      endTest(2, "wrapping burst read", startErr);
   endtask

   task automatic testConfig();
      int startErr;
      logic [DataWidth-1:0] d;
      startErr = errCount;
      randWord(d);
      chan1Op(cfgHdr(ReqCfgWr, 6'd5, 4'h4), d);
      modelCfg[5] = d;
      clearBeats();
      chan0Op(cfgHdr(ReqCfgRd, 6'd5, 4'h9));
      checkVal("beat count", 32'(beatData.size()), 32'd1);
      if (beatData.size() > 0) begin
         checkVal("rspData", beatData[0], modelCfg[5]);
         checkVal("rspTag", 32'(beatTag[0]), 32'h9);
      end
      checkViol(0, ViolNone);
      endTest(3, "config write and read", startErr);
   endtask

   task automatic testViolations();
      int startErr;
      logic [DataWidth-1:0] d;
      startErr = errCount;
      // three-line read still runs
      clearBeats();
      chan0Op(memHdr(ReqRdLine, Len3, 6'd62, 4'h2));
      checkBeats(6'd62, 3, 4'h2);
      checkViol(1, ViolRd3Line);
      // two-line write stores one word
      randWord(d);
      chan1Op(memHdr(ReqWrLine, Len2, 6'd30, 4'h5), d);
      model[30] = d;
      checkViol(2, ViolWrMulti);
      // legal config write keeps the last code
      randWord(d);
      chan1Op(cfgHdr(ReqCfgWr, 6'd1, 4'h8), d);
      modelCfg[1] = d;
      checkViol(2, ViolWrMulti);
      // index 9 aliases register 1
      clearBeats();
      chan0Op(cfgHdr(ReqCfgRd, 6'd9, 4'h3));
      checkVal("beat count", 32'(beatData.size()), 32'd1);
      if (beatData.size() > 0) begin
         checkVal("rspData", beatData[0], modelCfg[1]);
         checkVal("rspTag", 32'(beatTag[0]), 32'h3);
      end
      checkViol(3, ViolCfgRange);
      // channel 0 carries no data, line gets zero
      chan0Op(memHdr(ReqWrLine, Len1, 6'd20, 4'h6));
      model[20] = '0;
      checkViol(4, ViolWrongChan);
      endTest(4, "protocol violations", startErr);
   endtask

   task automatic testArbitration();
      int startErr;
      logic [DataWidth-1:0] d;
      startErr = errCount;
      randWord(d);
      chan1Op(memHdr(ReqWrLine, Len1, 6'd10, 4'h1), d);
      model[10] = d;
      // fresh reset, channel 0 first
      applyReset();
      for (int round = 0; round < 2; round++) begin
         randWord(d);
         clearBeats();
         fork
            chan0Op(memHdr(ReqRdLine, Len1, 6'd10, 4'hA));
            chan1Op(memHdr(ReqWrLine, Len1, 6'd10, 4'hB), d);
         join
         // read went first, sees the previous word
         checkBeats(6'd10, 1, 4'hA);
         model[10] = d;
      end
      // channel 0 served last, so channel 1 wins next
      clearBeats();
      chan0Op(memHdr(ReqRdLine, Len1, 6'd10, 4'hC));
      checkBeats(6'd10, 1, 4'hC);
      randWord(d);
      model[10] = d;
      clearBeats();
      fork
         chan0Op(memHdr(ReqRdLine, Len1, 6'd10, 4'hD));
         chan1Op(memHdr(ReqWrLine, Len1, 6'd10, 4'hE), d);
      join
      // write went first, read sees the new word
      checkBeats(6'd10, 1, 4'hD);
      checkViol(0, ViolNone);
      endTest(5, "round-robin arbitration", startErr);
   endtask

   initial begin
      for (int i = 0; i < CfgRegs; i++) begin
         modelCfg[i] = '0;
      end
      rstN = 1'b0;
      req0 = 1'b0;
      hdr0 = '0;
      req1 = 1'b0;
      hdr1 = '0;
      data1 = '0;
      repeat (ResetCycles) @(posedge clk);
      #1;
      rstN = 1'b1;
      testBasic();
      testWrap();
      testConfig();
      testViolations();
      testArbitration();
      $display("tests passed %0d, failed %0d, errors %0d", passCount, failCount, errCount);
      if (errCount == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(WatchdogCycles * ClkPeriod);
      $display("watchdog expired, tests did not finish in %0d cycles", WatchdogCycles);
      $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

// ==== ccipFabric.f ====
source/ccipPkg.sv
source/lineArbiter.sv
source/burstEngine.sv
source/protocolSniffer.sv
source/ccipFabric.sv
bench/ccipFabricTb.sv

// ==== runSim.sh ====
#!/bin/sh
# compile and run the fabric testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f ccipFabric.f --top-module ccipFabricTb -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -qx "Done: no errors" sim.log; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed"
   exit 1
fi

// ==== source/burstEngine.sv ====
/*
 * executes granted requests against the 64-line memory
 * and the config scratch registers
 * multi-line reads stream out one beat per cycle
 */
`default_nettype none

module burstEngine
   import ccipPkg::*;
(
   input  logic                 clk,
   input  logic                 rstN,
   input  logic                 start,
   input  reqHdr_u              hdr,
   input  logic [DataWidth-1:0] wrData,
   output logic                 done,
   output logic                 rspValid,
   output logic [DataWidth-1:0] rspData,
   output logic [TagWidth-1:0]  rspTag
);

   logic [DataWidth-1:0] lineMem [2**AddrWidth];
   logic [DataWidth-1:0] cfgReg [CfgRegs];

   // burst sequencer state
   logic                 busy;
   logic [AddrWidth-1:0] beatAddr;
   // beats still owed after the current one
   logic [1:0]           beatsLeft;

   // decoded request, valid only with start
   logic                   isRead;
   logic                   isWrite;
   logic                   isCfgRd;
   logic                   isCfgWr;
   logic [CfgIdxWidth-1:0] cfgIdx;
   logic [AddrWidth-1:0]   rdAddr;

   assign isRead  = start && (hdr.mem.reqType == ReqRdLine);
   assign isWrite = start && (hdr.mem.reqType == ReqWrLine);
   assign isCfgRd = start && (hdr.cfg.reqType == ReqCfgRd);
   assign isCfgWr = start && (hdr.cfg.reqType == ReqCfgWr);
   // only low index bits select a register
   assign cfgIdx  = hdr.cfg.index[CfgIdxWidth-1:0];
   // first beat straight from header, later ones from counter
   assign rdAddr  = busy ? beatAddr : hdr.mem.addr;

   // line writes, len ignored
   always_ff @(posedge clk) begin
      if (isWrite) begin
         lineMem[hdr.mem.addr] <= wrData;
      end
   end

   // scratch registers
   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < CfgRegs; i++) begin
            cfgReg[i] <= '0;
         end
      end else if (isCfgWr) begin
         cfgReg[cfgIdx] <= wrData;
      end
   end

   // sequencer and handshake
   always_ff @(posedge clk) begin
      if (!rstN) begin
         busy      <= 1'b0;
         done      <= 1'b0;
         rspValid  <= 1'b0;
         beatAddr  <= '0;
         beatsLeft <= '0;
      end else begin
         done     <= 1'b0;
         rspValid <= 1'b0;
         if (busy) begin
            rspValid  <= 1'b1;
            // wraps modulo 64
            beatAddr  <= beatAddr + 1'b1;
            beatsLeft <= beatsLeft - 1'b1;
            if (beatsLeft == 2'd1) begin
               // last beat
               busy <= 1'b0;
               done <= 1'b1;
            end
         end else if (isRead) begin
            rspValid  <= 1'b1;
            beatAddr  <= hdr.mem.addr + 1'b1;
            beatsLeft <= hdr.mem.len;
            if (hdr.mem.len == Len1) begin
               done <= 1'b1;
            end else begin
               busy <= 1'b1;
            end
         end else if (isCfgRd) begin
            rspValid <= 1'b1;
            done     <= 1'b1;
         end else if (isWrite || isCfgWr) begin
            done <= 1'b1;
         end
      end
   end

   // response payload, qualified by rspValid
   // hdr stays put until done so the tag is read live
   always_ff @(posedge clk) begin
      // tag bits are shared by both views
      rspTag <= hdr.mem.mdata;
      if (isCfgRd) begin
         rspData <= cfgReg[cfgIdx];
      end else begin
         rspData <= lineMem[rdAddr];
      end
   end

endmodule

`default_nettype wire

// ==== source/ccipFabric.sv ====
/*
 * top level of the request fabric
 * arbiter, burst engine and protocol sniffer
 */
`default_nettype none

module ccipFabric
   import ccipPkg::*;
(
   input  logic                  clk,
   input  logic                  rstN,
   // channel 0, reads
   input  logic                  req0,
   input  reqHdr_u               hdr0,
   output logic                  ack0,
   // channel 1, writes
   input  logic                  req1,
   input  reqHdr_u               hdr1,
   input  logic [DataWidth-1:0]  data1,
   output logic                  ack1,
   // response stream
   output logic                  rspValid,
   output logic [DataWidth-1:0]  rspData,
   output logic [TagWidth-1:0]   rspTag,
   // sniffer status
   output logic [CountWidth-1:0] violCount,
   output logic [2:0]            lastViol
);

   // granted request, held until done
   logic                 start;
   reqHdr_u              hdr;
   logic [DataWidth-1:0] wrData;
   logic                 grantChan;
   logic                 done;

   lineArbiter arb_i (
      .clk       (clk),
      .rstN      (rstN),
      .req0      (req0),
      .hdr0      (hdr0),
      .ack0      (ack0),
      .req1      (req1),
      .hdr1      (hdr1),
      .data1     (data1),
      .ack1      (ack1),
      .start     (start),
      .hdr       (hdr),
      .wrData    (wrData),
      .grantChan (grantChan),
      .done      (done)
   );

   burstEngine engine_i (
      .clk      (clk),
      .rstN     (rstN),
      .start    (start),
      .hdr      (hdr),
      .wrData   (wrData),
      .done     (done),
      .rspValid (rspValid),
      .rspData  (rspData),
      .rspTag   (rspTag)
   );

   // watches only, never stalls the engine
   protocolSniffer sniffer_i (
      .clk       (clk),
      .rstN      (rstN),
      .start     (start),
      .hdr       (hdr),
      .grantChan (grantChan),
      .violCount (violCount),
      .lastViol  (lastViol)
   );

endmodule

`default_nettype wire

// ==== source/ccipPkg.sv ====
/*
 * shared widths and sizes, request type and length codes,
 * violation codes, arbiter state encoding, and the request header
 * union with its memory and config views
 */
`default_nettype none

package ccipPkg;

   // datapath and address sizes
   localparam int DataWidth   = 32;
   localparam int AddrWidth   = 6;
   localparam int TagWidth    = 4;
   localparam int CfgRegs     = 8;
   localparam int CfgIdxWidth = $clog2(CfgRegs);
   // sniffer counter width, saturates at all ones
   localparam int CountWidth  = 8;

   // request types, top two bits of every header
   localparam logic [1:0] ReqRdLine = 2'd0;
   localparam logic [1:0] ReqWrLine = 2'd1;
   localparam logic [1:0] ReqCfgRd  = 2'd2;
   localparam logic [1:0] ReqCfgWr  = 2'd3;

   // line counts, code is lines minus one
   localparam logic [1:0] Len1 = 2'd0;
   localparam logic [1:0] Len2 = 2'd1;
   localparam logic [1:0] Len3 = 2'd2;
   localparam logic [1:0] Len4 = 2'd3;

   // rule violations, lower code wins
   localparam logic [2:0] ViolNone      = 3'd0;
   localparam logic [2:0] ViolRd3Line   = 3'd1;
   localparam logic [2:0] ViolWrMulti   = 3'd2;
   localparam logic [2:0] ViolCfgRange  = 3'd3;
   localparam logic [2:0] ViolWrongChan = 3'd4;

   // arbiter FSM
   localparam logic [1:0] ArbIdle = 2'd0;
   localparam logic [1:0] ArbBusy = 2'd1;
   localparam logic [1:0] ArbAck  = 2'd2;

   // one 16-bit header word, two decodings
   // tag sits in the low bits of both views
   typedef union packed {
      struct packed {
         logic [1:0]           reqType;
         logic [1:0]           vc;
         logic [1:0]           len;
         logic [AddrWidth-1:0] addr;
         logic [TagWidth-1:0]  mdata;
      } mem;
      struct packed {
         logic [1:0]          reqType;
         logic [3:0]          reserved;
         logic [5:0]          index;
         logic [TagWidth-1:0] tid;
      } cfg;
   } reqHdr_u;

endpackage

`default_nettype wire

// ==== source/lineArbiter.sv ====
/*
 * round-robin arbiter for two four-phase req/ack channels
 * latches the granted header and write data and holds them
 * for the burst engine until done
 */
`default_nettype none

module lineArbiter
   import ccipPkg::*;
(
   input  logic                 clk,
   input  logic                 rstN,
   input  logic                 req0,
   input  reqHdr_u              hdr0,
   output logic                 ack0,
   input  logic                 req1,
   input  reqHdr_u              hdr1,
   input  logic [DataWidth-1:0] data1,
   output logic                 ack1,
   output logic                 start,
   output reqHdr_u              hdr,
   output logic [DataWidth-1:0] wrData,
   output logic                 grantChan,
   input  logic                 done
);

   logic [1:0] state;
   // channel served most recently
   // resets to 1 so channel 0 wins the first contest
   logic lastServed;
   // winner if a grant happens this cycle
   logic pick;
   logic anyReq;
   // req line of the channel being served
   logic grantedReq;
   logic grantNow;

   assign anyReq     = req0 | req1;
   assign grantNow   = (state == ArbIdle) && anyReq;
   assign grantChan  = lastServed;
   assign grantedReq = lastServed ? req1 : req0;

   // round-robin pick
   always_comb begin
      if (req0 && req1) begin
         // both waiting, the other one goes
         pick = ~lastServed;
      end else begin
         pick = req1;
      end
   end

   // FSM, start pulse and acks
   always_ff @(posedge clk) begin
      if (!rstN) begin
         state      <= ArbIdle;
         lastServed <= 1'b1;
         start      <= 1'b0;
         ack0       <= 1'b0;
         ack1       <= 1'b0;
      end else begin
         start <= 1'b0;
         case (state)
            ArbIdle: begin
               if (anyReq) begin
                  state      <= ArbBusy;
                  start      <= 1'b1;
                  lastServed <= pick;
               end
            end
            ArbBusy: begin
               // engine finished, answer the host
               if (done) begin
                  state <= ArbAck;
                  ack0  <= ~lastServed;
                  ack1  <= lastServed;
               end
            end
            ArbAck: begin
               // wait for host to drop req
               if (!grantedReq) begin
                  state <= ArbIdle;
                  ack0  <= 1'b0;
                  ack1  <= 1'b0;
               end
            end
            default: begin
               state <= ArbIdle;
            end
         endcase
      end
   end

   // capture request on grant
   // host may change its inputs once ack is up
   always_ff @(posedge clk) begin
      if (grantNow) begin
         hdr <= pick ? hdr1 : hdr0;
         // channel 0 has no data bus
         wrData <= pick ? data1 : '0;
      end
   end

endmodule

`default_nettype wire

// ==== source/protocolSniffer.sv ====
/*
 * per-request protocol rule checker
 * keeps a saturating violation count and the last violation code
 */
`default_nettype none

module protocolSniffer
   import ccipPkg::*;
(
   input  logic                  clk,
   input  logic                  rstN,
   input  logic                  start,
   input  reqHdr_u               hdr,
   input  logic                  grantChan,
   output logic [CountWidth-1:0] violCount,
   output logic [2:0]            lastViol
);

   // request class
   logic isRdType;
   logic isWrType;
   logic isCfg;

   // individual rules
   logic rd3Line;
   logic wrMulti;
   logic cfgRange;
   logic wrongChan;
   logic [2:0] violCode;

   assign isRdType = (hdr.mem.reqType == ReqRdLine) || (hdr.cfg.reqType == ReqCfgRd);
   assign isWrType = (hdr.mem.reqType == ReqWrLine) || (hdr.cfg.reqType == ReqCfgWr);
   assign isCfg    = (hdr.cfg.reqType == ReqCfgRd) || (hdr.cfg.reqType == ReqCfgWr);

   // memory view rules
   assign rd3Line = (hdr.mem.reqType == ReqRdLine) && (hdr.mem.len == Len3);
   assign wrMulti = (hdr.mem.reqType == ReqWrLine) && (hdr.mem.len != Len1);
   // config view rule, full six-bit index
   assign cfgRange = isCfg && (hdr.cfg.index >= 6'(CfgRegs));
   // reads belong on channel 0, writes on channel 1
   assign wrongChan = (isRdType && grantChan) || (isWrType && !grantChan);

   // lowest code wins
   always_comb begin
      if (rd3Line) begin
         violCode = ViolRd3Line;
      end else if (wrMulti) begin
         violCode = ViolWrMulti;
      end else if (cfgRange) begin
         violCode = ViolCfgRange;
      end else if (wrongChan) begin
         violCode = ViolWrongChan;
      end else begin
         violCode = ViolNone;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         violCount <= '0;
         lastViol  <= ViolNone;
      end else if (start && (violCode != ViolNone)) begin
         lastViol <= violCode;
         // stick at all ones
         if (violCount != '1) begin
            violCount <= violCount + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire
